// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps -j 0
TOP       = tb_rammodel
FILELIST  = tb.f
PASS_MSG  = Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== bench/tb_rammodel.sv ====
`timescale 1ns/10ps

module tb_rammodel;
    import rammodel_pkg::*;

    localparam int ADDR_WIDTH     = 32;
    localparam int DATA_WIDTH     = 64;
    localparam int ID_WIDTH       = 4;
    localparam int MEM_DEPTH_LOG2 = 8;
    localparam int MEM_DEPTH      = 2 ** MEM_DEPTH_LOG2;
    localparam int DATA_BYTES     = DATA_WIDTH / 8;
    localparam int TIMEOUT        = 200;
    localparam int N_REQ          = 11;

    typedef struct packed {
        logic                  write;
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        len_t                  len;
    } req_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  avalid, aready, awrite;
    logic [ADDR_WIDTH-1:0] aaddr;
    logic [ID_WIDTH-1:0]   aid;
    len_t                  alen;
    size_t                 asize;
    burst_t                aburst;
    logic                  wvalid, wready, wlast;
    logic [DATA_WIDTH-1:0] wdata;
    logic                  bvalid, bready;
    logic [ID_WIDTH-1:0]   bid;
    logic                  rvalid, rready, rlast;
    logic [DATA_WIDTH-1:0] rdata;
    logic [ID_WIDTH-1:0]   rid;

    req_t                  reqs [N_REQ];
    logic [DATA_WIDTH-1:0] shadow [MEM_DEPTH];   // expected array contents
    logic [15:0]           lfsr_q;
    logic                  stall_en;
    logic                  timed_out;
    int                    data_errors;
    int                    id_errors;
    int                    last_errors;
    int                    flag_errors;

    always #4 clk = ~clk;

    rammodel_top #(
        .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH),
        .MEM_DEPTH_LOG2(MEM_DEPTH_LOG2)
    ) uut (
        .clk(clk), .rst(rst), .avalid(avalid), .aready(aready), .aaddr(aaddr),
        .aid(aid), .alen(alen), .asize(asize), .aburst(aburst), .awrite(awrite),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wlast(wlast),
        .bvalid(bvalid), .bready(bready), .bid(bid), .rvalid(rvalid),
        .rready(rready), .rdata(rdata), .rid(rid), .rlast(rlast)
    );

    // ####################
    // helpers
    // ####################

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? (s >> 1) ^ 16'hB400 : s >> 1;
    endfunction

    task automatic random_bits(input int n, output logic [63:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            bits   = {bits[62:0], lfsr_q[0]};   // one step per bit
        end
    endtask

    // data word index, wraps at the array depth
    function automatic int word_index(input logic [ADDR_WIDTH-1:0] addr, input int beat);
        return int'((addr / DATA_BYTES + beat) % MEM_DEPTH);
    endfunction

    task automatic load_table();
        reqs[0]  = '{1'b1, 4'd1,  32'h0000_0000, 8'd3};
        reqs[1]  = '{1'b0, 4'd2,  32'h0000_0000, 8'd3};
        reqs[2]  = '{1'b1, 4'd3,  32'h0000_0100, 8'd0};
        reqs[3]  = '{1'b0, 4'd4,  32'h0000_0100, 8'd0};
        reqs[4]  = '{1'b1, 4'd5,  32'h0000_07E8, 8'd5};   // crosses the top
        reqs[5]  = '{1'b0, 4'd6,  32'h0000_07E8, 8'd5};
        reqs[6]  = '{1'b0, 4'd7,  32'h0000_0000, 8'd3};
        reqs[7]  = '{1'b1, 4'd8,  32'h1000_0040, 8'd7};   // aliases onto 0x40
        reqs[8]  = '{1'b0, 4'd9,  32'h0000_0040, 8'd7};
        reqs[9]  = '{1'b1, 4'd10, 32'h0000_07F8, 8'd1};
        reqs[10] = '{1'b0, 4'd15, 32'h0000_07F0, 8'd3};
    endtask

    // advance one clock and drive the ready inputs
    task automatic next_cycle();
        logic [63:0] bits;
        @(posedge clk);
        #1;
        if (stall_en) begin
            random_bits(4, bits);
            bready = |bits[1:0];
            rready = |bits[3:2];
        end else begin
            bready = 1'b1;
            rready = 1'b1;
        end
    endtask

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        $display("timeout at %0t: %s did not happen within %0d cycles", $time, what, TIMEOUT);
    endtask

    // ####################
    // compare tasks
    // ####################

    task automatic check_data(input logic [DATA_WIDTH-1:0] got, input logic [DATA_WIDTH-1:0] exp,
                              input int beat);
        if (got !== exp) begin
            data_errors++;
            $display("mismatch at %0t: rdata beat %0d got %h expected %h", $time, beat, got, exp);
        end
    endtask

    task automatic check_id(input string what, input logic [ID_WIDTH-1:0] got,
                            input logic [ID_WIDTH-1:0] exp);
        if (got !== exp) begin
            id_errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_last(input logic got, input logic exp, input int beat);
        if (got !== exp) begin
            last_errors++;
            $display("mismatch at %0t: rlast on beat %0d got %b expected %b", $time, beat, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // ####################
    // host driver
    // ####################

    task automatic send_request(input req_t r);
        int   cycles;
        logic taken;
        avalid = 1'b1;
        awrite = r.write;
        aid    = r.id;
        aaddr  = r.addr;
        alen   = r.len;
        cycles = 0;
        taken  = 1'b0;
        while (!taken && cycles < TIMEOUT) begin
            @(negedge clk);
            taken = aready;
            next_cycle();
            cycles++;
        end
        avalid = 1'b0;
        if (!taken)
            report_timeout("address handshake");
    endtask

    task automatic send_beats(input req_t r);
        logic [63:0] bits;
        int          beat;
        int          cycles;
        logic        taken;
        if (timed_out)
            return;
        for (beat = 0; beat <= int'(r.len) && !timed_out; beat++) begin
            random_bits(DATA_WIDTH, bits);
            wvalid = 1'b1;
            wdata  = bits;
            wlast  = beat == int'(r.len);
            cycles = 0;
            taken  = 1'b0;
            while (!taken && cycles < TIMEOUT) begin
                @(negedge clk);
                taken = wready;
                next_cycle();
                cycles++;
            end
            if (taken)
                shadow[word_index(r.addr, beat)] = bits;
            else
                report_timeout("write data handshake");
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
    endtask

    task automatic collect_write(input req_t r);
        int   cycles;
        logic taken;
        if (timed_out)
            return;
        cycles = 0;
        taken  = 1'b0;
        while (!taken && cycles < TIMEOUT) begin
            @(negedge clk);
            check_flag("rvalid during write", rvalid, 1'b0);
            if (bvalid && bready) begin
                taken = 1'b1;
                check_id("bid", bid, r.id);
            end
            next_cycle();
            cycles++;
        end
        if (!taken)
            report_timeout("write response");
    endtask

    task automatic collect_read(input req_t r);
        int cycles;
        int beat;
        if (timed_out)
            return;
        beat   = 0;
        cycles = 0;
        while (beat <= int'(r.len) && cycles < TIMEOUT) begin
            @(negedge clk);
            check_flag("bvalid during read", bvalid, 1'b0);
            if (rvalid && rready) begin
                check_data(rdata, shadow[word_index(r.addr, beat)], beat);
                check_id("rid", rid, r.id);
                check_last(rlast, beat == int'(r.len), beat);
                beat++;
                cycles = 0;   // timeout restarts for each beat
            end
            next_cycle();
            cycles++;
        end
        if (beat <= int'(r.len))
            report_timeout("read beat");
    endtask

    // no extra response may follow a delivered result
    task automatic check_quiet();
        int i;
        if (timed_out)
            return;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            check_flag("bvalid after result", bvalid, 1'b0);
            check_flag("rvalid after result", rvalid, 1'b0);
            next_cycle();
        end
    endtask

    // ####################
    // main sequence
    // ####################

    initial begin
        int pass;
        int n;
        data_errors = 0;
        id_errors   = 0;
        last_errors = 0;
        flag_errors = 0;
        lfsr_q      = 16'd14;
        timed_out   = 1'b0;
        stall_en    = 1'b0;
        rst         = 1'b1;
        avalid      = 1'b0;
        aaddr       = '0;
        aid         = '0;
        alen        = '0;
        asize       = 3'd3;    // 8 byte beats
        aburst      = 2'b01;   // incrementing
        awrite      = 1'b0;
        wvalid      = 1'b0;
        wdata       = '0;
        wlast       = 1'b0;
        bready      = 1'b1;
        rready      = 1'b1;
        load_table();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        for (n = 0; n < 8; n++) begin
            @(negedge clk);
            check_flag("aready after reset", aready, 1'b1);
            check_flag("wready after reset", wready, 1'b0);
            check_flag("bvalid after reset", bvalid, 1'b0);
            check_flag("rvalid after reset", rvalid, 1'b0);
            next_cycle();
        end

        for (pass = 0; pass < 2 && !timed_out; pass++) begin
            stall_en = pass == 1;   // second pass with random back-pressure
            for (n = 0; n < N_REQ && !timed_out; n++) begin
                send_request(reqs[n]);
                if (reqs[n].write) begin
                    send_beats(reqs[n]);
                    collect_write(reqs[n]);
                end else begin
                    collect_read(reqs[n]);
                end
                check_quiet();
            end
        end

        $display("errors: data %0d, id %0d, last %0d, flag %0d, timeout %0d",
                 data_errors, id_errors, last_errors, flag_errors, int'(timed_out));
        if (data_errors + id_errors + last_errors + flag_errors == 0 && !timed_out)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== logic/rammodel_decoder.sv ====
`timescale 1ns/10ps

module rammodel_decoder #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 64,
    parameter int ID_WIDTH   = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  link_valid,
    output logic                  link_ready,
    input  rammodel_pkg::word_t   link_word,
    output logic                  req_valid,
    input  logic                  req_ready,
    output logic                  req_write,
    output logic [ID_WIDTH-1:0]   req_id,
    output rammodel_pkg::len_t    req_len,
    output logic [ADDR_WIDTH-1:0] req_addr,
    output logic                  beat_valid,
    input  logic                  beat_ready,
    output logic [DATA_WIDTH-1:0] beat_data
);
    import rammodel_pkg::*;

    localparam bit ADDR_64 = ADDR_WIDTH > 32;

    typedef enum logic [2:0] {
        st_head, st_addr_1, st_addr_2, st_req, st_low, st_high
    } state_t;

    state_t      state;
    logic [63:0] addr_q;
    word_t       low_q;        // low half of the beat being built
    len_t        beats_left;
    logic        link_fire;

    assign link_fire = link_valid && link_ready;
    assign req_addr  = addr_q[ADDR_WIDTH-1:0];

    always_comb begin
        case (state)
            st_req:  link_ready = 1'b0;          // request register full
            st_high: link_ready = !beat_valid;   // beat register full
            default: link_ready = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_head;
            req_valid  <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            if (beat_valid && beat_ready)
                beat_valid <= 1'b0;
            case (state)
                st_head: if (link_fire) state <= st_addr_1;
                st_addr_1: if (link_fire) begin
                    state     <= ADDR_64 ? st_addr_2 : st_req;
                    req_valid <= !ADDR_64;
                end
                st_addr_2: if (link_fire) begin
                    state     <= st_req;
                    req_valid <= 1'b1;
                end
                st_req: if (req_ready) begin
                    req_valid <= 1'b0;
                    state     <= req_write ? st_low : st_head;
                end
                st_low: if (link_fire) state <= st_high;
                st_high: if (link_fire) begin
                    beat_valid <= 1'b1;
                    state      <= beats_left == '0 ? st_head : st_low;
                end
                default: state <= st_head;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (link_fire) begin
            case (state)
                st_head: begin
                    req_write  <= link_word[HDR_WRITE_BIT];
                    req_id     <= link_word[HDR_ID_LSB +: ID_WIDTH];
                    req_len    <= link_word[HDR_LEN_LSB +: 8];
                    beats_left <= link_word[HDR_LEN_LSB +: 8];
                end
                st_addr_1: addr_q[31:0]  <= link_word;
                st_addr_2: addr_q[63:32] <= link_word;
                st_low:    low_q         <= link_word;
                st_high: begin
                    beat_data  <= {link_word, low_q};
                    beats_left <= beats_left - 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== logic/rammodel_encoder_a.sv ====
`timescale 1ns/10ps

module rammodel_encoder_a #(
    parameter int ADDR_WIDTH = 32,
    parameter int ID_WIDTH   = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  avalid,
    output logic                  aready,
    input  logic [ADDR_WIDTH-1:0] aaddr,
    input  logic [ID_WIDTH-1:0]   aid,
    input  rammodel_pkg::len_t    alen,
    input  rammodel_pkg::size_t   asize,
    input  rammodel_pkg::burst_t  aburst,
    input  logic                  awrite,
    output logic                  enc_valid,
    input  logic                  enc_ready,
    output rammodel_pkg::word_t   enc_word,
    output logic                  idle
);
    import rammodel_pkg::*;

    localparam bit ADDR_64 = ADDR_WIDTH > 32;

    typedef enum logic [1:0] {st_idle, st_head, st_addr_1, st_addr_2} state_t;

    state_t      state;
    logic [63:0] addr_q;   // zero-extended request address
    word_t       header;
    logic        a_fire;
    logic        enc_fire;

    assign a_fire    = avalid && aready;
    assign enc_fire  = enc_valid && enc_ready;
    assign aready    = state == st_idle;
    assign idle      = state == st_idle;
    assign enc_valid = state != st_idle;

    always_comb begin
        header                         = '0;
        header[HDR_WRITE_BIT]          = awrite;
        header[HDR_BURST_LSB +: 2]     = aburst;
        header[HDR_SIZE_LSB +: 3]      = asize;
        header[HDR_LEN_LSB +: 8]       = alen;
        header[HDR_ID_LSB +: ID_WIDTH] = aid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:   if (a_fire) state <= st_head;
                st_head:   if (enc_fire) state <= st_addr_1;
                st_addr_1: if (enc_fire) state <= ADDR_64 ? st_addr_2 : st_idle;
                st_addr_2: if (enc_fire) state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (a_fire)
            addr_q <= 64'(aaddr);
        if (state == st_idle && a_fire)
            enc_word <= header;           // header goes out first
        else if (state == st_head && enc_fire)
            enc_word <= addr_q[31:0];     // low address word
        else if (state == st_addr_1 && enc_fire)
            enc_word <= addr_q[63:32];
    end

endmodule

// ==== logic/rammodel_memory.sv ====
`timescale 1ns/10ps

module rammodel_memory #(
    parameter int ADDR_WIDTH     = 32,
    parameter int DATA_WIDTH     = 64,
    parameter int ID_WIDTH       = 4,
    parameter int MEM_DEPTH_LOG2 = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_write,
    input  logic [ID_WIDTH-1:0]   req_id,
    input  rammodel_pkg::len_t    req_len,
    input  logic [ADDR_WIDTH-1:0] req_addr,
    input  logic                  beat_valid,
    output logic                  beat_ready,
    input  logic [DATA_WIDTH-1:0] beat_data,
    output logic                  b_valid,
    input  logic                  b_ready,
    output logic [ID_WIDTH-1:0]   b_id,
    output logic                  rd_valid,
    input  logic                  rd_ready,
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic [ID_WIDTH-1:0]   rd_id,
    output logic                  rd_last
);
    import rammodel_pkg::*;

    localparam int BYTE_SHIFT = $clog2(DATA_WIDTH / 8);

    logic [DATA_WIDTH-1:0]     mem [2**MEM_DEPTH_LOG2];
    logic                      busy;       // one request held at a time
    logic                      write_q;
    logic [ID_WIDTH-1:0]       id_q;
    len_t                      len_q;
    len_t                      beat_cnt;
    logic [MEM_DEPTH_LOG2-1:0] idx;        // wraps at the array depth
    logic                      req_fire;
    logic                      beat_fire;
    logic                      rd_fire;

    assign req_fire  = req_valid && req_ready;
    assign beat_fire = beat_valid && beat_ready;
    assign rd_fire   = rd_valid && rd_ready;

    assign req_ready  = !busy;
    assign beat_ready = busy && write_q && !b_valid;
    assign rd_valid   = busy && !write_q;
    assign rd_data    = mem[idx];
    assign rd_last    = beat_cnt == len_q;
    assign rd_id      = id_q;
    assign b_id       = id_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            b_valid <= 1'b0;
        end else if (req_fire) begin
            busy <= 1'b1;
        end else if (beat_fire && beat_cnt == len_q) begin
            b_valid <= 1'b1;             // single response per write burst
        end else if (b_valid && b_ready) begin
            b_valid <= 1'b0;
            busy    <= 1'b0;
        end else if (rd_fire && rd_last) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            write_q  <= req_write;
            id_q     <= req_id;
            len_q    <= req_len;
            beat_cnt <= '0;
            idx      <= req_addr[BYTE_SHIFT +: MEM_DEPTH_LOG2];
        end else if (beat_fire || rd_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            idx      <= idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_fire)
            mem[idx] <= beat_data;
    end

endmodule

// ==== logic/rammodel_pkg.sv ====
package rammodel_pkg;

    // ####################
    // link and header field types
    // ####################

    typedef logic [31:0] word_t;   // one link word
    typedef logic [7:0]  len_t;    // beats minus one
    typedef logic [2:0]  size_t;
    typedef logic [1:0]  burst_t;

    // ####################
    // header word layout
    // ####################

    localparam int HDR_WRITE_BIT = 0;
    localparam int HDR_BURST_LSB = 3;    // bits 2..1 stay zero
    localparam int HDR_SIZE_LSB  = 5;
    localparam int HDR_LEN_LSB   = 8;
    localparam int HDR_ID_LSB    = 16;   // id zero-extended to 16 bits

endpackage

// ==== logic/rammodel_response.sv ====
`timescale 1ns/10ps

module rammodel_response #(
    parameter int DATA_WIDTH = 64,
    parameter int ID_WIDTH   = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  b_valid,
    output logic                  b_ready,
    input  logic [ID_WIDTH-1:0]   b_id,
    input  logic                  rd_valid,
    output logic                  rd_ready,
    input  logic [DATA_WIDTH-1:0] rd_data,
    input  logic [ID_WIDTH-1:0]   rd_id,
    input  logic                  rd_last,
    output logic                  bvalid,
    input  logic                  bready,
    output logic [ID_WIDTH-1:0]   bid,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic [ID_WIDTH-1:0]   rid,
    output logic                  rlast
);

    // register takes a new entry when empty or draining
    assign b_ready  = !bvalid || bready;
    assign rd_ready = !rvalid || rready;

    // ####################
    // write response
    // ####################

    always_ff @(posedge clk) begin
        if (rst)
            bvalid <= 1'b0;
        else if (b_ready)
            bvalid <= b_valid;
    end

    always_ff @(posedge clk) begin
        if (b_valid && b_ready)
            bid <= b_id;
    end

    // ####################
    // read data
    // ####################

    always_ff @(posedge clk) begin
        if (rst)
            rvalid <= 1'b0;
        else if (rd_ready)
            rvalid <= rd_valid;
    end

    always_ff @(posedge clk) begin
        if (rd_valid && rd_ready) begin
            rdata <= rd_data;
            rid   <= rd_id;
            rlast <= rd_last;
        end
    end

endmodule

// ==== logic/rammodel_stream_join.sv ====
`timescale 1ns/10ps

module rammodel_stream_join #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enc_valid,
    output logic                  enc_ready,
    input  rammodel_pkg::word_t   enc_word,
    input  logic                  idle,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic                  wlast,
    output logic                  link_valid,
    input  logic                  link_ready,
    output rammodel_pkg::word_t   link_word
);
    import rammodel_pkg::*;

    typedef enum logic [1:0] {st_pass, st_low, st_high} state_t;

    state_t     state;
    logic [1:0] word_cnt;     // position inside the encoder message
    logic       write_pend;   // write header seen, data still to come
    len_t       beats_left;
    logic       enc_fire;
    logic       link_fire;

    assign enc_fire  = enc_valid && enc_ready;
    assign link_fire = link_valid && link_ready;

    assign enc_ready  = state == st_pass && link_ready;
    assign wready     = state == st_high && link_ready;   // beat pops on its high word
    assign link_valid = state == st_pass ? enc_valid : wvalid;

    always_comb begin
        case (state)
            st_low:  link_word = wdata[31:0];
            st_high: link_word = word_t'(wdata[DATA_WIDTH-1:32]);
            default: link_word = enc_word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_pass;
            word_cnt   <= '0;
            write_pend <= 1'b0;
        end else begin
            if (idle)
                word_cnt <= '0;
            else if (enc_fire)
                word_cnt <= word_cnt + 1'b1;

            case (state)
                st_pass: begin
                    if (enc_fire && word_cnt == 2'd0)
                        write_pend <= enc_word[HDR_WRITE_BIT];
                    else if (idle && write_pend) begin
                        write_pend <= 1'b0;
                        state      <= st_low;
                    end
                end
                st_low:  if (link_fire) state <= st_high;
                st_high: if (link_fire) state <= beats_left == '0 ? st_pass : st_low;
                default: state <= st_pass;
            endcase
        end
    end

    // wlast is not trusted for framing, the header length is
    always_ff @(posedge clk) begin
        if (state == st_pass && enc_fire && word_cnt == 2'd0)
            beats_left <= enc_word[HDR_LEN_LSB +: 8];
        else if (state == st_high && link_fire)
            beats_left <= beats_left - 1'b1;
    end

endmodule

// ==== logic/rammodel_top.sv ====
`timescale 1ns/10ps

module rammodel_top #(
    parameter int ADDR_WIDTH     = 32,
    parameter int DATA_WIDTH     = 64,
    parameter int ID_WIDTH       = 4,
    parameter int MEM_DEPTH_LOG2 = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  avalid,
    output logic                  aready,
    input  logic [ADDR_WIDTH-1:0] aaddr,
    input  logic [ID_WIDTH-1:0]   aid,
    input  rammodel_pkg::len_t    alen,
    input  rammodel_pkg::size_t   asize,
    input  rammodel_pkg::burst_t  aburst,
    input  logic                  awrite,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic                  wlast,
    output logic                  bvalid,
    input  logic                  bready,
    output logic [ID_WIDTH-1:0]   bid,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic [ID_WIDTH-1:0]   rid,
    output logic                  rlast
);
    import rammodel_pkg::*;

    logic                  enc_valid, enc_ready, idle;
    word_t                 enc_word;
    logic                  link_valid, link_ready;
    word_t                 link_word;
    logic                  req_valid, req_ready, req_write;
    logic [ID_WIDTH-1:0]   req_id;
    len_t                  req_len;
    logic [ADDR_WIDTH-1:0] req_addr;
    logic                  beat_valid, beat_ready;
    logic [DATA_WIDTH-1:0] beat_data;
    logic                  b_valid, b_ready;
    logic [ID_WIDTH-1:0]   b_id;
    logic                  rd_valid, rd_ready, rd_last;
    logic [DATA_WIDTH-1:0] rd_data;
    logic [ID_WIDTH-1:0]   rd_id;

    // ####################
    // host side link
    // ####################

    rammodel_encoder_a #(.ADDR_WIDTH(ADDR_WIDTH), .ID_WIDTH(ID_WIDTH)) u_encoder (
        .clk(clk), .rst(rst), .avalid(avalid), .aready(aready), .aaddr(aaddr),
        .aid(aid), .alen(alen), .asize(asize), .aburst(aburst), .awrite(awrite),
        .enc_valid(enc_valid), .enc_ready(enc_ready), .enc_word(enc_word), .idle(idle)
    );

    rammodel_stream_join #(.DATA_WIDTH(DATA_WIDTH)) u_join (
        .clk(clk), .rst(rst), .enc_valid(enc_valid), .enc_ready(enc_ready),
        .enc_word(enc_word), .idle(idle), .wvalid(wvalid), .wready(wready),
        .wdata(wdata), .wlast(wlast), .link_valid(link_valid),
        .link_ready(link_ready), .link_word(link_word)
    );

    // ####################
    // model side
    // ####################

    rammodel_decoder #(
        .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)
    ) u_decode (
        .clk(clk), .rst(rst), .link_valid(link_valid), .link_ready(link_ready),
        .link_word(link_word), .req_valid(req_valid), .req_ready(req_ready),
        .req_write(req_write), .req_id(req_id), .req_len(req_len), .req_addr(req_addr),
        .beat_valid(beat_valid), .beat_ready(beat_ready), .beat_data(beat_data)
    );

    rammodel_memory #(
        .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH),
        .MEM_DEPTH_LOG2(MEM_DEPTH_LOG2)
    ) u_execute (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_ready(req_ready),
        .req_write(req_write), .req_id(req_id), .req_len(req_len), .req_addr(req_addr),
        .beat_valid(beat_valid), .beat_ready(beat_ready), .beat_data(beat_data),
        .b_valid(b_valid), .b_ready(b_ready), .b_id(b_id), .rd_valid(rd_valid),
        .rd_ready(rd_ready), .rd_data(rd_data), .rd_id(rd_id), .rd_last(rd_last)
    );

    rammodel_response #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) u_result (
        .clk(clk), .rst(rst), .b_valid(b_valid), .b_ready(b_ready), .b_id(b_id),
        .rd_valid(rd_valid), .rd_ready(rd_ready), .rd_data(rd_data), .rd_id(rd_id),
        .rd_last(rd_last), .bvalid(bvalid), .bready(bready), .bid(bid),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rid(rid), .rlast(rlast)
    );

endmodule

// ==== tb.f ====
logic/rammodel_pkg.sv
logic/rammodel_encoder_a.sv
logic/rammodel_stream_join.sv
logic/rammodel_decoder.sv
logic/rammodel_memory.sv
logic/rammodel_response.sv
logic/rammodel_top.sv
bench/tb_rammodel.sv
